//--- bp_bank.sv
module bp_bank import bp_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,

	// Lookup side
	input  logic                lookup_i,
	input  logic [row_bits-1:0] lookup_row_i,
	input  logic [tag_bits-1:0] lookup_tag_i,

	// Update side
	input  logic                upd_i,
	input  logic [row_bits-1:0] upd_row_i,
	input  logic [tag_bits-1:0] upd_tag_i,
	input  logic                upd_taken_i,
	input  logic [xlen-1:0]     upd_target_i,

	// Registered read result
	output logic                hit_o,
	output logic                ctr_taken_o,
	output logic [xlen-1:0]     target_o
);

	logic [bank_rows-1:0] valid_q;
	logic [tag_bits-1:0]  tag_mem    [bank_rows];
	logic [1:0]           ctr_mem    [bank_rows];
	logic [xlen-1:0]      target_mem [bank_rows];

	logic       lookup_match;
	logic       upd_match;
	logic [1:0] upd_ctr_cur;
	logic [1:0] upd_ctr_next;

	assign lookup_match = valid_q[lookup_row_i] && (tag_mem[lookup_row_i] == lookup_tag_i);
	assign upd_match    = valid_q[upd_row_i] && (tag_mem[upd_row_i] == upd_tag_i);
	assign upd_ctr_cur  = ctr_mem[upd_row_i];

	// Next counter state for the updated entry
	always_comb begin
		if (!upd_match) begin
			// Claimed entry starts biased toward the first outcome
			upd_ctr_next = upd_taken_i ? ctr_weak_t : ctr_strong_nt;
		end else begin
			case (upd_ctr_cur)
				ctr_strong_nt: upd_ctr_next = upd_taken_i ? ctr_weak_nt : ctr_strong_nt;
				ctr_weak_nt:   upd_ctr_next = upd_taken_i ? ctr_weak_t : ctr_strong_nt;
				ctr_weak_t:    upd_ctr_next = upd_taken_i ? ctr_strong_t : ctr_weak_nt;
				default:       upd_ctr_next = upd_taken_i ? ctr_strong_t : ctr_weak_t;
			endcase
		end
	end

	// Valid bits, all entries invalid out of reset
	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			valid_q <= '0;
		end else if (upd_i) begin
			valid_q[upd_row_i] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clk_i) begin
		if (upd_i) begin
			tag_mem[upd_row_i] <= upd_tag_i;
			ctr_mem[upd_row_i] <= upd_ctr_next;
			// Target kept on a not taken hit
			if (upd_taken_i || !upd_match) begin
				target_mem[upd_row_i] <= upd_target_i;
			end
		end
	end

	// Registered read, a same cycle update is not visible yet
	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			hit_o <= 1'b0;
		end else if (lookup_i) begin
			hit_o <= lookup_match;
		end
	end

	always_ff @(posedge clk_i) begin
		if (lookup_i) begin
			ctr_taken_o <= ctr_mem[lookup_row_i][1];  // Taken half of the counter
			target_o    <= target_mem[lookup_row_i];
		end
	end

endmodule

//--- bp_index_router.sv
module bp_index_router import bp_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,

	input  logic                 lookup_valid_i,
	input  logic [xlen-1:0]      lookup_pc_i,
	input  logic                 upd_valid_i,
	input  logic                 upd_taken_i,
	input  logic [xlen-1:0]      upd_pc_i,
	input  logic [xlen-1:0]      upd_target_i,

	output logic [num_banks-1:0] bank_lookup_o,
	output logic [row_bits-1:0]  lookup_row_o,
	output logic [tag_bits-1:0]  lookup_tag_o,
	output logic [num_banks-1:0] bank_upd_o,
	output logic [row_bits-1:0]  upd_row_o,
	output logic [tag_bits-1:0]  upd_tag_o,
	output logic                 upd_taken_o,
	output logic [xlen-1:0]      upd_target_o,

	output logic                 ctx_valid_o,
	output logic [bank_bits-1:0] ctx_bank_o,
	output logic [xlen-1:0]      ctx_pc_o
);

	logic [bank_bits-1:0] lookup_bank;
	logic [bank_bits-1:0] upd_bank;

	// Field slicing, row and tag are shared by all banks
	assign lookup_bank  = lookup_pc_i[bank_lsb +: bank_bits];
	assign lookup_row_o = lookup_pc_i[row_lsb +: row_bits];
	assign lookup_tag_o = lookup_pc_i[tag_lsb +: tag_bits];

	assign upd_bank  = upd_pc_i[bank_lsb +: bank_bits];
	assign upd_row_o = upd_pc_i[row_lsb +: row_bits];
	assign upd_tag_o = upd_pc_i[tag_lsb +: tag_bits];

	assign upd_taken_o  = upd_taken_i;
	assign upd_target_o = upd_target_i;

	// One-hot bank strobes
	always_comb begin
		bank_lookup_o = '0;
		bank_upd_o    = '0;
		bank_lookup_o[lookup_bank] = lookup_valid_i;
		bank_upd_o[upd_bank]       = upd_valid_i;
	end

	// Lookup context for the merge stage, lines up with bank read data
	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			ctx_valid_o <= 1'b0;
		end else begin
			ctx_valid_o <= lookup_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (lookup_valid_i) begin
			ctx_bank_o <= lookup_bank;
			ctx_pc_o   <= lookup_pc_i;   // Needed for the fall-through pc
		end
	end

endmodule

//--- bp_pkg.sv
package bp_pkg;

	// Core widths
	localparam int xlen = 32;             // Pc and target width

	// Entry geometry, 128 entries over four banks
	localparam int num_banks = 4;
	localparam int bank_bits = 2;
	localparam int bank_rows = 32;
	localparam int row_bits  = 5;
	localparam int tag_bits  = 23;

	// Field positions inside a word aligned pc
	localparam int bank_lsb = 2;                     // pc[3:2]
	localparam int row_lsb  = bank_lsb + bank_bits;  // pc[8:4]
	localparam int tag_lsb  = row_lsb + row_bits;    // pc[31:9]

	// Bimodal counter states
	// High bit set means predict taken
	localparam logic [1:0] ctr_strong_nt = 2'b00;
	localparam logic [1:0] ctr_weak_nt   = 2'b01;
	localparam logic [1:0] ctr_weak_t    = 2'b10;
	localparam logic [1:0] ctr_strong_t  = 2'b11;

	// Register map
	localparam int axil_addr_bits = 5;

	localparam logic [axil_addr_bits-1:0] reg_ctrl           = 5'h00;
	localparam logic [axil_addr_bits-1:0] reg_pred_taken     = 5'h04;
	localparam logic [axil_addr_bits-1:0] reg_pred_not_taken = 5'h08;
	localparam logic [axil_addr_bits-1:0] reg_res_taken      = 5'h0C;
	localparam logic [axil_addr_bits-1:0] reg_res_not_taken  = 5'h10;

	// Control register fields
	localparam int ctrl_en_bit  = 0;  // Predict enable, resets to 1
	localparam int ctrl_clr_bit = 1;  // Clear counters, self clearing

endpackage

//--- bp_result_merge.sv
module bp_result_merge import bp_pkg::*; (
	// Lookup context from the router
	input  logic                            ctx_valid_i,
	input  logic [bank_bits-1:0]            ctx_bank_i,
	input  logic [xlen-1:0]                 ctx_pc_i,

	// Bank responses
	input  logic [num_banks-1:0]            bank_hit_i,
	input  logic [num_banks-1:0]            bank_ctr_taken_i,
	input  logic [num_banks-1:0][xlen-1:0]  bank_target_i,

	input  logic                            predict_en_i,

	output logic                            pred_valid_o,
	output logic                            pred_taken_o,
	output logic [xlen-1:0]                 pred_pc_o,
	output logic                            pred_taken_pulse_o
);

	logic            sel_hit;
	logic            sel_ctr_taken;
	logic [xlen-1:0] sel_target;
	logic [xlen-1:0] fall_through_pc;
	logic            taken;

	// Only the bank that owned the pc answers
	assign sel_hit       = bank_hit_i[ctx_bank_i];
	assign sel_ctr_taken = bank_ctr_taken_i[ctx_bank_i];
	assign sel_target    = bank_target_i[ctx_bank_i];

	assign fall_through_pc = ctx_pc_i + xlen'(4);  // Next sequential instruction

	assign taken = ctx_valid_i && predict_en_i && sel_hit && sel_ctr_taken;

	assign pred_valid_o = ctx_valid_i;
	assign pred_taken_o = taken;
	assign pred_pc_o    = taken ? sel_target : fall_through_pc;

	// Event strobe for the statistics block
	assign pred_taken_pulse_o = taken;

endmodule

//--- bp_stats_axil.sv
module bp_stats_axil import bp_pkg::*; (
	input  logic                      clk_i,
	input  logic                      rst_i,

	// Event sources
	input  logic                      pred_valid_i,
	input  logic                      pred_taken_i,
	input  logic                      upd_valid_i,
	input  logic                      upd_taken_i,

	output logic                      predict_en_o,

	// AXI4-Lite slave
	input  logic                      s_awvalid_i,
	input  logic [axil_addr_bits-1:0] s_awaddr_i,
	output logic                      s_awready_o,
	input  logic                      s_wvalid_i,
	input  logic [31:0]               s_wdata_i,
	input  logic [3:0]                s_wstrb_i,
	output logic                      s_wready_o,
	output logic                      s_bvalid_o,
	output logic [1:0]                s_bresp_o,
	input  logic                      s_bready_i,
	input  logic                      s_arvalid_i,
	input  logic [axil_addr_bits-1:0] s_araddr_i,
	output logic                      s_arready_o,
	output logic                      s_rvalid_o,
	output logic [31:0]               s_rdata_o,
	output logic [1:0]                s_rresp_o,
	input  logic                      s_rready_i
);

	logic        wr_fire;
	logic        rd_fire;
	logic        ctrl_wr;
	logic        clr;
	logic [3:0]  cnt_evt;
	logic [31:0] cnt_q [4];
	logic [31:0] rd_word;

	// AW and W only move together, and only with B free
	assign s_awready_o = !s_bvalid_o && s_wvalid_i;
	assign s_wready_o  = !s_bvalid_o && s_awvalid_i;
	assign wr_fire     = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
	assign s_bresp_o   = 2'b00;  // OKAY

	assign s_arready_o = !s_rvalid_o;
	assign rd_fire     = s_arvalid_i && s_arready_o;
	assign s_rresp_o   = 2'b00;  // OKAY, unknown offsets included

	assign ctrl_wr = wr_fire && (s_awaddr_i == reg_ctrl) && s_wstrb_i[0];
	assign clr     = ctrl_wr && s_wdata_i[ctrl_clr_bit];

	// Order: pred taken, pred not taken, res taken, res not taken
	assign cnt_evt = {upd_valid_i && !upd_taken_i, upd_valid_i && upd_taken_i,
		pred_valid_i && !pred_taken_i, pred_valid_i && pred_taken_i};

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			predict_en_o <= 1'b1;
		end else if (ctrl_wr) begin
			predict_en_o <= s_wdata_i[ctrl_en_bit];
		end
	end

	// Wrapping event counters, clear wins over a same cycle event
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < 4; i++) begin
			if (!rst_i || clr) begin
				cnt_q[i] <= '0;
			end else if (cnt_evt[i]) begin
				cnt_q[i] <= cnt_q[i] + 32'd1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			s_bvalid_o <= 1'b0;
		end else if (wr_fire) begin
			s_bvalid_o <= 1'b1;
		end else if (s_bready_i) begin
			s_bvalid_o <= 1'b0;
		end
	end

	// Read decode
	always_comb begin
		rd_word = '0;
		case (s_araddr_i)
			reg_ctrl:           rd_word[ctrl_en_bit] = predict_en_o;  // Clear bit reads 0
			reg_pred_taken:     rd_word = cnt_q[0];
			reg_pred_not_taken: rd_word = cnt_q[1];
			reg_res_taken:      rd_word = cnt_q[2];
			reg_res_not_taken:  rd_word = cnt_q[3];
			default:            rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			s_rvalid_o <= 1'b0;
		end else if (rd_fire) begin
			s_rvalid_o <= 1'b1;
		end else if (s_rready_i) begin
			s_rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_fire) begin
			s_rdata_o <= rd_word;  // Held while R is stalled
		end
	end

endmodule

//--- branch_predictor.sv
module branch_predictor import bp_pkg::*; (
	input  logic                      clk_i,
	input  logic                      rst_i,

	// Fetch lookup
	input  logic                      lookup_valid_i,
	input  logic [xlen-1:0]           lookup_pc_i,
	output logic                      pred_valid_o,
	output logic                      pred_taken_o,
	output logic [xlen-1:0]           pred_pc_o,

	// Resolved branch update
	input  logic                      upd_valid_i,
	input  logic                      upd_taken_i,
	input  logic [xlen-1:0]           upd_pc_i,
	input  logic [xlen-1:0]           upd_target_i,

	// Register port
	input  logic                      s_awvalid_i,
	input  logic [axil_addr_bits-1:0] s_awaddr_i,
	output logic                      s_awready_o,
	input  logic                      s_wvalid_i,
	input  logic [31:0]               s_wdata_i,
	input  logic [3:0]                s_wstrb_i,
	output logic                      s_wready_o,
	output logic                      s_bvalid_o,
	output logic [1:0]                s_bresp_o,
	input  logic                      s_bready_i,
	input  logic                      s_arvalid_i,
	input  logic [axil_addr_bits-1:0] s_araddr_i,
	output logic                      s_arready_o,
	output logic                      s_rvalid_o,
	output logic [31:0]               s_rdata_o,
	output logic [1:0]                s_rresp_o,
	input  logic                      s_rready_i
);

	logic [num_banks-1:0]           bank_lookup;
	logic [row_bits-1:0]            lookup_row;
	logic [tag_bits-1:0]            lookup_tag;
	logic [num_banks-1:0]           bank_upd;
	logic [row_bits-1:0]            upd_row;
	logic [tag_bits-1:0]            upd_tag;
	logic                           upd_taken;
	logic [xlen-1:0]                upd_target;
	logic                           ctx_valid;
	logic [bank_bits-1:0]           ctx_bank;
	logic [xlen-1:0]                ctx_pc;
	logic [num_banks-1:0]           bank_hit;
	logic [num_banks-1:0]           bank_ctr_taken;
	logic [num_banks-1:0][xlen-1:0] bank_target;
	logic                           predict_en;
	logic                           pred_taken_pulse;

	bp_index_router u_router (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.lookup_valid_i (lookup_valid_i),
		.lookup_pc_i    (lookup_pc_i),
		.upd_valid_i    (upd_valid_i),
		.upd_taken_i    (upd_taken_i),
		.upd_pc_i       (upd_pc_i),
		.upd_target_i   (upd_target_i),
		.bank_lookup_o  (bank_lookup),
		.lookup_row_o   (lookup_row),
		.lookup_tag_o   (lookup_tag),
		.bank_upd_o     (bank_upd),
		.upd_row_o      (upd_row),
		.upd_tag_o      (upd_tag),
		.upd_taken_o    (upd_taken),
		.upd_target_o   (upd_target),
		.ctx_valid_o    (ctx_valid),
		.ctx_bank_o     (ctx_bank),
		.ctx_pc_o       (ctx_pc)
	);

	// One bank per pc[3:2] value
	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		bp_bank u_bank (
			.clk_i        (clk_i),
			.rst_i        (rst_i),
			.lookup_i     (bank_lookup[b]),
			.lookup_row_i (lookup_row),
			.lookup_tag_i (lookup_tag),
			.upd_i        (bank_upd[b]),
			.upd_row_i    (upd_row),
			.upd_tag_i    (upd_tag),
			.upd_taken_i  (upd_taken),
			.upd_target_i (upd_target),
			.hit_o        (bank_hit[b]),
			.ctr_taken_o  (bank_ctr_taken[b]),
			.target_o     (bank_target[b])
		);
	end

	bp_result_merge u_merge (
		.ctx_valid_i        (ctx_valid),
		.ctx_bank_i         (ctx_bank),
		.ctx_pc_i           (ctx_pc),
		.bank_hit_i         (bank_hit),
		.bank_ctr_taken_i   (bank_ctr_taken),
		.bank_target_i      (bank_target),
		.predict_en_i       (predict_en),
		.pred_valid_o       (pred_valid_o),
		.pred_taken_o       (pred_taken_o),
		.pred_pc_o          (pred_pc_o),
		.pred_taken_pulse_o (pred_taken_pulse)
	);

	// Resolved events come straight from the update inputs
	bp_stats_axil u_stats (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.pred_valid_i (pred_valid_o),
		.pred_taken_i (pred_taken_pulse),
		.upd_valid_i  (upd_valid_i),
		.upd_taken_i  (upd_taken_i),
		.predict_en_o (predict_en),
		.s_awvalid_i  (s_awvalid_i),
		.s_awaddr_i   (s_awaddr_i),
		.s_awready_o  (s_awready_o),
		.s_wvalid_i   (s_wvalid_i),
		.s_wdata_i    (s_wdata_i),
		.s_wstrb_i    (s_wstrb_i),
		.s_wready_o   (s_wready_o),
		.s_bvalid_o   (s_bvalid_o),
		.s_bresp_o    (s_bresp_o),
		.s_bready_i   (s_bready_i),
		.s_arvalid_i  (s_arvalid_i),
		.s_araddr_i   (s_araddr_i),
		.s_arready_o  (s_arready_o),
		.s_rvalid_o   (s_rvalid_o),
		.s_rdata_o    (s_rdata_o),
		.s_rresp_o    (s_rresp_o),
		.s_rready_i   (s_rready_i)
	);

endmodule

//--- list.f
bp_pkg.sv
bp_index_router.sv
bp_bank.sv
bp_result_merge.sv
bp_stats_axil.sv
branch_predictor.sv
tb_branch_predictor.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_branch_predictor -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "Simulation ok" \
	|| { echo "Simulation not ok"; exit 1; }

exit 0

//--- tb_branch_predictor.sv
module tb_branch_predictor import bp_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic                      clk_i;
	logic                      rst_i;
	logic                      lookup_valid_i;
	logic [xlen-1:0]           lookup_pc_i;
	logic                      pred_valid_o;
	logic                      pred_taken_o;
	logic [xlen-1:0]           pred_pc_o;
	logic                      upd_valid_i;
	logic                      upd_taken_i;
	logic [xlen-1:0]           upd_pc_i;
	logic [xlen-1:0]           upd_target_i;
	logic                      s_awvalid_i;
	logic [axil_addr_bits-1:0] s_awaddr_i;
	logic                      s_awready_o;
	logic                      s_wvalid_i;
	logic [31:0]               s_wdata_i;
	logic [3:0]                s_wstrb_i;
	logic                      s_wready_o;
	logic                      s_bvalid_o;
	logic [1:0]                s_bresp_o;
	logic                      s_bready_i;
	logic                      s_arvalid_i;
	logic [axil_addr_bits-1:0] s_araddr_i;
	logic                      s_arready_o;
	logic                      s_rvalid_o;
	logic [31:0]               s_rdata_o;
	logic [1:0]                s_rresp_o;
	logic                      s_rready_i;

	// Reference copy of all 128 entries, indexed by pc[8:2]
	logic                m_valid  [128];
	logic [tag_bits-1:0] m_tag    [128];
	logic [1:0]          m_ctr    [128];
	logic [xlen-1:0]     m_target [128];
	logic                model_en;

	logic [xlen:0]   exp_q [$];    // {taken, next pc}
	logic [xlen:0]   exp_entry;
	logic            lookup_seen_q;
	logic [xlen-1:0] pc_pool [16];
	int              tally [4];    // Pred taken, pred not taken, res taken, res not taken
	int              mism_cnt = 0;
	int              timeout_cnt = 0;
	integer          seed = 99896;

	branch_predictor uut (.*);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// Expected result of a lookup against the current model contents
	function automatic logic [xlen:0] predict_ref(input logic [xlen-1:0] pc);
		logic [6:0] idx;
		logic       hit;
		idx = pc[8:2];
		hit = m_valid[idx] && (m_tag[idx] == pc[31:9]);
		if (model_en && hit && m_ctr[idx][1])
			return {1'b1, m_target[idx]};
		return {1'b0, pc + 32'd4};
	endfunction

	task automatic train_ref(input logic [xlen-1:0] pc, input logic taken,
		input logic [xlen-1:0] target);
		logic [6:0] idx;
		idx = pc[8:2];
		if (m_valid[idx] && (m_tag[idx] == pc[31:9])) begin
			if (taken) begin
				m_ctr[idx]    = (m_ctr[idx] == 2'b11) ? 2'b11 : m_ctr[idx] + 2'd1;
				m_target[idx] = target;
			end else begin
				m_ctr[idx] = (m_ctr[idx] == 2'b00) ? 2'b00 : m_ctr[idx] - 2'd1;
			end
		end else begin
			// Miss claims the entry
			m_valid[idx]  = 1'b1;
			m_tag[idx]    = pc[31:9];
			m_ctr[idx]    = taken ? ctr_weak_t : ctr_strong_nt;
			m_target[idx] = target;
		end
	endtask

	function automatic logic [xlen-1:0] rand_pc();
		logic [31:0] r;
		r = $random(seed);
		return {r[31:2], 2'b00};
	endfunction

	// One fetch cycle, driven on the falling edge
	task automatic drive_cycle(input logic lv, input logic [xlen-1:0] lpc, input logic uv,
		input logic ut, input logic [xlen-1:0] upc, input logic [xlen-1:0] utgt);
		@(negedge clk_i);
		lookup_valid_i = lv;
		lookup_pc_i    = lpc;
		upd_valid_i    = uv;
		upd_taken_i    = ut;
		upd_pc_i       = upc;
		upd_target_i   = utgt;
		if (lv)
			exp_q.push_back(predict_ref(lpc));  // Sees the old contents
		if (uv) begin
			train_ref(upc, ut, utgt);
			if (ut)
				tally[2]++;
			else
				tally[3]++;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic mixed_stream(input int n);
		logic [31:0]     r;
		logic [xlen-1:0] lpc;
		logic [xlen-1:0] upc;
		repeat (n) begin
			r   = $random(seed);
			lpc = pc_pool[r[3:0]];
			upc = r[8] ? lpc : pc_pool[r[7:4]];  // Same entry as the lookup half the time
			drive_cycle(r[9] | r[10], lpc, r[11], r[12] | r[13], upc, rand_pc());
		end
	endtask

	task automatic axil_write(input logic [axil_addr_bits-1:0] addr, input logic [31:0] data);
		int waited;
		@(negedge clk_i);
		s_awvalid_i = 1'b1;
		s_awaddr_i  = addr;
		s_wvalid_i  = 1'b1;
		s_wdata_i   = data;
		s_wstrb_i   = 4'hF;
		#1;  // Ready follows the valids within the low phase
		assert (s_awready_o && s_wready_o) else begin
			mism_cnt++;
			$display("** Error: s_awready_o = %h, s_wready_o = %h, expected %h",
				s_awready_o, s_wready_o, 1'b1);
		end
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
		end while (!s_bvalid_o && waited < 20);
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		if (!s_bvalid_o) begin
			timeout_cnt++;
			$display("Timeout: no write response for offset %h", addr);
		end else begin
			assert (s_bresp_o == 2'b00) else begin
				mism_cnt++;
				$display("** Error: s_bresp_o = %h, expected %h", s_bresp_o, 2'b00);
			end
		end
	endtask

	task automatic axil_read(input logic [axil_addr_bits-1:0] addr, output logic [31:0] data);
		int waited;
		@(negedge clk_i);
		s_arvalid_i = 1'b1;
		s_araddr_i  = addr;
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
		end while (!s_rvalid_o && waited < 20);
		s_arvalid_i = 1'b0;
		data = s_rdata_o;
		if (!s_rvalid_o) begin
			timeout_cnt++;
			$display("Timeout: no read response for offset %h", addr);
		end else begin
			assert (s_rresp_o == 2'b00) else begin
				mism_cnt++;
				$display("** Error: s_rresp_o = %h, expected %h", s_rresp_o, 2'b00);
			end
		end
	endtask

	task automatic check_reg(input logic [axil_addr_bits-1:0] addr, input logic [31:0] expected);
		logic [31:0] data;
		axil_read(addr, data);
		assert (data == expected) else begin
			mism_cnt++;
			$display("** Error: s_rdata_o at offset %h = %h, expected %h", addr, data, expected);
		end
	endtask

	task automatic check_stats();
		check_reg(reg_pred_taken, tally[0]);
		check_reg(reg_pred_not_taken, tally[1]);
		check_reg(reg_res_taken, tally[2]);
		check_reg(reg_res_not_taken, tally[3]);
	endtask

	always @(posedge clk_i) lookup_seen_q <= lookup_valid_i;

	// Comparison against the queued reference results
	always @(negedge clk_i) begin
		if (rst_i) begin
			assert (pred_valid_o == lookup_seen_q) else begin
				mism_cnt++;
				$display("** Error: pred_valid_o = %h, expected %h", pred_valid_o, lookup_seen_q);
			end
			if (pred_valid_o) begin
				if (exp_q.size() == 0) begin
					mism_cnt++;
					$display("A prediction came out with no lookup waiting for it");
				end else begin
					exp_entry = exp_q.pop_front();
					if (exp_entry[xlen])
						tally[0]++;
					else
						tally[1]++;
					assert (pred_taken_o == exp_entry[xlen]) else begin
						mism_cnt++;
						$display("** Error: pred_taken_o = %h, expected %h",
							pred_taken_o, exp_entry[xlen]);
					end
					assert (pred_pc_o == exp_entry[xlen-1:0]) else begin
						mism_cnt++;
						$display("** Error: pred_pc_o = %h, expected %h",
							pred_pc_o, exp_entry[xlen-1:0]);
					end
				end
			end
		end
	end

	initial begin
		logic [31:0]     r;
		logic [xlen-1:0] pc_a;
		logic [xlen-1:0] pc_b;
		logic [xlen-1:0] tgt;
		rst_i = 1'b0;
		lookup_valid_i = 1'b0;
		lookup_pc_i = '0;
		upd_valid_i = 1'b0;
		upd_taken_i = 1'b0;
		upd_pc_i = '0;
		upd_target_i = '0;
		s_awvalid_i = 1'b0;
		s_awaddr_i = '0;
		s_wvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wstrb_i = '0;
		s_bready_i = 1'b1;
		s_arvalid_i = 1'b0;
		s_araddr_i = '0;
		s_rready_i = 1'b1;
		model_en = 1'b1;
		for (int i = 0; i < 128; i++)
			m_valid[i] = 1'b0;
		for (int i = 0; i < 4; i++)
			tally[i] = 0;
		// Eight spread over all banks, eight more aliasing them with other tags
		for (int i = 0; i < 16; i++) begin
			if (i < 8) begin
				pc_pool[i] = rand_pc();
				pc_pool[i][3:2] = 2'(i);
			end else begin
				pc_pool[i] = pc_pool[i-8] ^ (32'h1 << (9 + i));
			end
		end

		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b1;
		assert (s_arready_o && !s_bvalid_o && !s_rvalid_o) else begin
			mism_cnt++;
			$display("AXI-Lite handshake signals are wrong after reset");
		end

		// Cold table, every lookup falls through
		repeat (24) begin
			r = $random(seed);
			drive_cycle(r[0], rand_pc(), 1'b0, 1'b0, '0, '0);
		end

		// Train to strongly taken, then step back down
		pc_a = pc_pool[1];
		tgt  = rand_pc();
		repeat (3) drive_cycle(1'b0, '0, 1'b1, 1'b1, pc_a, tgt);
		drive_cycle(1'b1, pc_a, 1'b0, 1'b0, '0, '0);
		drive_cycle(1'b0, '0, 1'b1, 1'b0, pc_a, '0);
		drive_cycle(1'b1, pc_a, 1'b0, 1'b0, '0, '0);
		drive_cycle(1'b0, '0, 1'b1, 1'b0, pc_a, '0);
		drive_cycle(1'b1, pc_a, 1'b0, 1'b0, '0, '0);

		// Same bank and row, other tag
		pc_b = pc_a ^ 32'h0010_0000;
		drive_cycle(1'b0, '0, 1'b1, 1'b1, pc_b, rand_pc());
		drive_cycle(1'b1, pc_a, 1'b0, 1'b0, '0, '0);
		drive_cycle(1'b1, pc_b, 1'b0, 1'b0, '0, '0);

		mixed_stream(400);
		idle_cycles(2);

		// Statistics, then clear
		check_stats();
		check_reg(reg_ctrl, 32'h1);
		check_reg(5'h14, 32'h0);
		axil_write(reg_ctrl, 32'h3);
		for (int i = 0; i < 4; i++)
			tally[i] = 0;
		check_stats();
		check_reg(reg_ctrl, 32'h1);  // Clear bit does not stick

		// Predictions off, then back on
		axil_write(reg_ctrl, 32'h0);
		model_en = 1'b0;
		mixed_stream(60);
		idle_cycles(2);
		check_stats();
		axil_write(reg_ctrl, 32'h1);
		model_en = 1'b1;
		mixed_stream(60);
		idle_cycles(2);
		check_stats();

		if (exp_q.size() != 0) begin
			mism_cnt++;
			$display("%0d lookups never produced a prediction", exp_q.size());
		end
		$display("Errors: %0d mismatches, %0d timeouts", mism_cnt, timeout_cnt);
		if (mism_cnt == 0 && timeout_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
